//--- common/video_pkg.sv
// Panel timing constants and the types that carry video timing and TMDS symbols.
// Used by the timing generator, the encoders and the top level.
`default_nettype none

package video_pkg;

    // panel mode, small enough that a full frame simulates quickly
    localparam int h_active = 64;
    localparam int h_total  = 80;
    localparam int v_active = 48;
    localparam int v_total  = 56;

    // sync windows, active high, start inclusive and end exclusive
    localparam int h_sync_start = 68;
    localparam int h_sync_end   = 76;
    localparam int v_sync_start = 50;
    localparam int v_sync_end   = 52;

    typedef logic [6:0] coord_t;  // covers 0..h_total-1

    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;
        logic   vsync;
        logic   de;     // active area
        logic   frame;  // first pixel of frame
        logic   line;   // first pixel of line
    } timing_t;

    typedef logic [9:0] tmds_sym_t;

    typedef struct packed {
        tmds_sym_t ch2;  // red
        tmds_sym_t ch1;  // green
        tmds_sym_t ch0;  // blue, carries hsync/vsync in blanking
    } tmds_bus_t;

    // DVI control symbols, indexed by {c1, c0}
    localparam tmds_sym_t tmds_ctrl [4] = '{
        10'b1101010100,
        10'b0010101011,
        10'b0101010100,
        10'b1010101011
    };

endpackage

`default_nettype wire

//--- common/fb_pkg.sv
// Framebuffer geometry, colour types, palette and Wishbone bus structs.
`default_nettype none

package fb_pkg;

    localparam int fb_width  = 16;
    localparam int fb_height = 12;
    localparam int fb_scale  = 4;   // must stay a power of two
    localparam int fb_depth  = fb_width * fb_height;
    localparam int fb_addr_w = 8;

    typedef logic [3:0] cidx_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // 16 colour palette in the usual PC text-mode order, entry 0 black
    localparam rgb_t palette [16] = '{
        12'h000, 12'h00a, 12'h0a0, 12'h0aa,
        12'ha00, 12'ha0a, 12'ha50, 12'haaa,
        12'h555, 12'h55f, 12'h5f5, 12'h5ff,
        12'hf55, 12'hf5f, 12'hff5, 12'hfff
    };

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [fb_addr_w-1:0] adr;
        cidx_t                dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        cidx_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- hw/display_timings.sv
// Screen position counters and registered sync, data enable and frame/line pulses.
// One pixel per clk_pix, output bundled as a timing struct.
`default_nettype none
`timescale 1ns/10ps

module display_timings (
    input  wire logic         clk_pix,
    input  wire logic         arst_n,
    output video_pkg::timing_t timing
);

    video_pkg::coord_t x;  // running position
    video_pkg::coord_t y;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            x <= '0;
            y <= '0;
        end else if (x == video_pkg::h_total - 1) begin
            x <= '0;
            if (y == video_pkg::v_total - 1) begin
                y <= '0;
            end else begin
                y <= y + 1'b1;
            end
        end else begin
            x <= x + 1'b1;
        end
    end

    // everything below derives from the same counter values, so all fields agree
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            timing <= '0;
        end else begin
            timing.sx    <= x;
            timing.sy    <= y;
            timing.hsync <= (x >= video_pkg::h_sync_start) && (x < video_pkg::h_sync_end);
            timing.vsync <= (y >= video_pkg::v_sync_start) && (y < video_pkg::v_sync_end);
            timing.de    <= (x < video_pkg::h_active) && (y < video_pkg::v_active);
            timing.frame <= (x == 0) && (y == 0);
            timing.line  <= (x == 0);
        end
    end

endmodule

`default_nettype wire

//--- framebuffer/framebuffer.sv
// Colour index memory with a Wishbone classic port and a scaled scan-out read.
// Scan-out looks up the palette and returns rgb one cycle after the timing input.
`default_nettype none
`timescale 1ns/10ps

module framebuffer (
    input  wire logic               clk_pix,
    input  wire logic               arst_n,
    input  wire fb_pkg::wb_req_t    wb_req,
    output fb_pkg::wb_rsp_t         wb_rsp,
    input  wire video_pkg::timing_t timing,
    output fb_pkg::rgb_t            pixel
);

    fb_pkg::cidx_t mem [fb_pkg::fb_depth];

    logic          ack;
    fb_pkg::cidx_t rd_dat;
    logic          bus_req;   // new transfer this cycle
    logic          bus_hit;   // address inside memory
    video_pkg::coord_t fb_x;
    video_pkg::coord_t fb_y;
    logic [fb_pkg::fb_addr_w-1:0] scan_addr;

    initial begin
        for (int i = 0; i < fb_pkg::fb_depth; i++) begin
            mem[i] = '0;
        end
    end

    assign bus_req = wb_req.cyc && wb_req.stb && !ack;
    assign bus_hit = wb_req.adr < fb_pkg::fb_depth;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= bus_req;  // single cycle, low again while stb drops
        end
    end

    // write lands on the same edge that raises ack
    always_ff @(posedge clk_pix) begin
        if (bus_req && wb_req.we && bus_hit) begin
            mem[wb_req.adr] <= wb_req.dat;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (bus_req) begin
            rd_dat <= bus_hit ? mem[wb_req.adr] : '0;  // out of range reads as 0
        end
    end

    assign wb_rsp = '{ack: ack, dat: rd_dat};

    // scale is a power of two so the divide is a shift
    assign fb_x = timing.sx >> $clog2(fb_pkg::fb_scale);
    assign fb_y = timing.sy >> $clog2(fb_pkg::fb_scale);
    assign scan_addr = fb_pkg::fb_addr_w'(fb_y * fb_pkg::fb_width + fb_x);

    always_ff @(posedge clk_pix) begin
        if (timing.de) begin
            pixel <= fb_pkg::palette[mem[scan_addr]];
        end else begin
            pixel <= '0;  // black in blanking
        end
    end

endmodule

`default_nettype wire

//--- tmds/tmds_encoder.sv
// DVI 1.0 TMDS encoder for one channel: 8b/10b with running disparity.
// Sends one of the four control symbols while de is low. One cycle latency.
`default_nettype none
`timescale 1ns/10ps

module tmds_encoder (
    input  wire logic       clk_pix,
    input  wire logic       arst_n,
    input  wire logic       de,
    input  wire logic [7:0] data,
    input  wire logic [1:0] ctrl,
    output video_pkg::tmds_sym_t sym
);

    logic [3:0]        n1_d;
    logic              use_xnor;
    logic [8:0]        q_m;       // transition minimised word
    logic [3:0]        n1_q;
    logic [3:0]        n0_q;
    logic signed [4:0] bias;      // ones minus zeros of q_m[7:0]
    logic signed [4:0] cnt;       // running disparity
    logic signed [4:0] cnt_next;
    video_pkg::tmds_sym_t sym_next;

    assign n1_d     = 4'($countones(data));
    assign use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !data[0]);

    // stage 1: xor or xnor chain, bit 8 records which
    always_comb begin
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            if (use_xnor) begin
                q_m[i] = ~(q_m[i-1] ^ data[i]);
            end else begin
                q_m[i] = q_m[i-1] ^ data[i];
            end
        end
        q_m[8] = !use_xnor;
    end

    assign n1_q = 4'($countones(q_m[7:0]));
    assign n0_q = 4'd8 - n1_q;
    assign bias = 5'(n1_q) - 5'(n0_q);

    // stage 2: dc balance, invert when it pulls disparity back toward zero
    always_comb begin
        if (cnt == 0 || n1_q == n0_q) begin
            sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            if (q_m[8]) begin
                cnt_next = cnt + bias;
            end else begin
                cnt_next = cnt - bias;
            end
        end else if ((cnt > 0 && n1_q > n0_q) || (cnt < 0 && n0_q > n1_q)) begin
            sym_next = {1'b1, q_m[8], ~q_m[7:0]};
            cnt_next = cnt - bias + (q_m[8] ? 5'sd2 : 5'sd0);
        end else begin
            sym_next = {1'b0, q_m[8], q_m[7:0]};
            cnt_next = cnt + bias - (q_m[8] ? 5'sd0 : 5'sd2);
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
            sym <= video_pkg::tmds_ctrl[0];
        end else if (de) begin
            cnt <= cnt_next;
            sym <= sym_next;
        end else begin
            cnt <= '0;  // disparity restarts each active period
            sym <= video_pkg::tmds_ctrl[ctrl];
        end
    end

endmodule

`default_nettype wire

//--- hw/video_top.sv
// Display pipeline top: timing generator, framebuffer, sync delay and three
// TMDS encoders. Hands out parallel 10-bit symbols per channel.
`default_nettype none
`timescale 1ns/10ps

module video_top (
    input  wire logic            clk_pix,
    input  wire logic            arst_n,
    input  wire fb_pkg::wb_req_t wb_req,
    output fb_pkg::wb_rsp_t      wb_rsp,
    output video_pkg::tmds_bus_t tmds,
    output logic                 frame_start
);

    video_pkg::timing_t   timing;
    video_pkg::timing_t   timing_d;      // aligned with pixel
    fb_pkg::rgb_t         pixel;
    logic [3:0]           chan_data [3];
    logic [1:0]           chan_ctrl [3];
    video_pkg::tmds_sym_t chan_sym  [3];

    display_timings timings_i (
        .clk_pix,
        .arst_n,
        .timing
    );

    framebuffer fb_i (
        .clk_pix,
        .arst_n,
        .wb_req,
        .wb_rsp,
        .timing,
        .pixel
    );

    // framebuffer read takes one cycle, hold timing back to match
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            timing_d <= '0;
        end else begin
            timing_d <= timing;
        end
    end

    assign frame_start = timing_d.frame;

    assign chan_data[0] = pixel.blue;
    assign chan_data[1] = pixel.green;
    assign chan_data[2] = pixel.red;
    assign chan_ctrl[0] = {timing_d.vsync, timing_d.hsync};  // sync rides on blue
    assign chan_ctrl[1] = 2'b00;
    assign chan_ctrl[2] = 2'b00;

    for (genvar i = 0; i < 3; i++) begin : enc_g
        tmds_encoder enc_i (
            .clk_pix,
            .arst_n,
            .de   (timing_d.de),
            .data ({2{chan_data[i]}}),  // 4-bit channel widened to 8 bits
            .ctrl (chan_ctrl[i]),
            .sym  (chan_sym[i])
        );
    end

    assign tmds = '{ch2: chan_sym[2], ch1: chan_sym[1], ch0: chan_sym[0]};

endmodule

`default_nettype wire

//--- test/video_properties.sv
// Concurrent checks on the framebuffer Wishbone port and the timing struct it
// receives from the timing generator. Bound into every framebuffer instance.
`default_nettype none
`timescale 1ns/10ps

module video_properties (
    input wire logic               clk_pix,
    input wire logic               arst_n,
    input wire fb_pkg::wb_req_t    wb_req,
    input wire fb_pkg::wb_rsp_t    wb_rsp,
    input wire video_pkg::timing_t timing
);

    int failures = 0;

    ack_single: assert property (@(posedge clk_pix) disable iff (!arst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack held for more than one cycle");
            failures++;
        end

    // ack only answers a request seen the cycle before
    ack_after_req: assert property (@(posedge clk_pix) disable iff (!arst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            $error("ack without a preceding cyc and stb");
            failures++;
        end

    de_in_active: assert property (@(posedge clk_pix) disable iff (!arst_n)
        timing.de |-> (timing.sx < video_pkg::h_active) && (timing.sy < video_pkg::v_active))
        else begin
            $error("de high outside the active area");
            failures++;
        end

    frame_at_origin: assert property (@(posedge clk_pix) disable iff (!arst_n)
        timing.frame == (timing.line && timing.sx == 0 && timing.sy == 0))
        else begin
            $error("frame pulse not at screen origin");
            failures++;
        end

endmodule

bind framebuffer video_properties props_i (.clk_pix, .arst_n, .wb_req, .wb_rsp, .timing);

`default_nettype wire

//--- test/tb_video_top.sv
// Testbench for the display pipeline. Reads vectors from test/video_tests.txt,
// drives the Wishbone port and decodes the TMDS symbols against expected colours.
`default_nettype none
`timescale 1ns/10ps

module tb_video_top;

    logic                 clk_pix;
    logic                 arst_n;
    fb_pkg::wb_req_t      wb_req;
    fb_pkg::wb_rsp_t      wb_rsp;
    video_pkg::tmds_bus_t tmds;
    logic                 frame_start;

    string       kinds [$];
    int          xs [$];
    int          ys [$];
    logic [3:0]  idxs [$];
    logic [11:0] rgbs [$];
    bit          used [256];    // framebuffer addresses touched by vectors
    logic [31:0] rng = 32'hb1f4;
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          reset_errs;

    video_top dut_i (.clk_pix, .arst_n, .wb_req, .wb_rsp, .tmds, .frame_start);

    always #20 clk_pix = ~clk_pix;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // undo the optional inversion and then the xor/xnor chain
    function automatic logic [7:0] decode_data(input video_pkg::tmds_sym_t sym);
        logic [7:0] q;
        logic [7:0] d;
        q = sym[9] ? ~sym[7:0] : sym[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = sym[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return d;
    endfunction

    // control pair {c1, c0} or -1 for anything else
    function automatic int decode_ctrl(input video_pkg::tmds_sym_t sym);
        case (sym)
            10'b1101010100: return 0;
            10'b0010101011: return 1;
            10'b0101010100: return 2;
            10'b1010101011: return 3;
            default:        return -1;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) begin
            failed++;
            $display("fail %s", name);
        end else begin
            $display("pass %s", name);
        end
    endtask

    task automatic finish_run();
        int props_failed;
        props_failed = dut_i.fb_i.props_i.failures;
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests, failed, errors, props_failed);
        if (errors == 0 && props_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // one classic cycle with the request held until ack and stb dropped the cycle after
    task automatic transfer(input string name, input logic is_write, input int adr,
                            input logic [3:0] dat, output logic [3:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk_pix);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: is_write, adr: 8'(adr), dat: dat};
        @(negedge clk_pix);
        while (!wb_rsp.ack) begin
            if (waited == 16) begin
                $display("no Wishbone ack within 16 cycles in %s", name);
                errors++;
                finish_run();
            end
            waited++;
            @(negedge clk_pix);
        end
        rdat = wb_rsp.dat;
        @(posedge clk_pix);
        wb_req <= '0;
        @(negedge clk_pix);
        check({name, "_ack_once"}, 0, wb_rsp.ack);
    endtask

    task automatic wb_write(input string name, input int adr, input logic [3:0] dat);
        logic [3:0] ignored;
        transfer(name, 1'b1, adr, dat, ignored);
    endtask

    task automatic wb_read(input string name, input int adr, output logic [3:0] dat);
        transfer(name, 1'b0, adr, 4'h0, dat);
    endtask

    // random indices into addresses no vector looks at
    task automatic fill_unused();
        int adr;
        for (int k = 0; k < 4; k++) begin
            rng = xorshift(rng);
            adr = int'(rng % fb_pkg::fb_depth);
            if (!used[adr]) begin
                wb_write("filler", adr, rng[7:4]);
            end
        end
    endtask

    task automatic wait_frame();
        int waited;
        waited = 0;
        @(negedge clk_pix);
        while (!frame_start) begin
            if (waited == 6000) begin
                $display("frame_start did not arrive within 6000 cycles");
                errors++;
                finish_run();
            end
            waited++;
            @(negedge clk_pix);
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       kind;
        string       rest;
        int          x;
        int          y;
        logic [31:0] idx;
        logic [31:0] rgb;
        fd = $fopen("test/video_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/video_tests.txt");
            errors++;
            finish_run();
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind.substr(0, 0) == "#") begin
                n = $fgets(rest, fd);  // comment line
            end else begin
                n = $fscanf(fd, "%d %d %h %h", x, y, idx, rgb);
                if (n != 4) begin
                    $display("malformed %s line in test file", kind);
                    errors++;
                end
                kinds.push_back(kind);
                xs.push_back(x);
                ys.push_back(y);
                idxs.push_back(idx[3:0]);
                rgbs.push_back(rgb[11:0]);
                // pixel vectors are in screen coordinates
                if (kind == "pixel") begin
                    used[(y / fb_pkg::fb_scale) * fb_pkg::fb_width + x / fb_pkg::fb_scale] = 1'b1;
                end else begin
                    used[y * fb_pkg::fb_width + x] = 1'b1;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int i);
        string       name;
        int          errs;
        int          adr;
        logic [3:0]  rd;
        logic [23:0] expected;
        logic [23:0] actual;
        name = $sformatf("%s_%0d_%0d", kinds[i], xs[i], ys[i]);
        errs = errors;
        adr = ys[i] * fb_pkg::fb_width + xs[i];
        case (kinds[i])
            "write": begin
                wb_write(name, adr, idxs[i]);
                wb_read(name, adr, rd);
                check(name, idxs[i], rd);
                fill_unused();
            end
            "read": begin
                wb_read(name, adr, rd);
                check(name, idxs[i], rd);
            end
            "pixel": begin
                wait_frame();
                // symbol for (x,y) trails frame_start by y*h_total + x + 1
                repeat (ys[i] * video_pkg::h_total + xs[i] + 1) @(negedge clk_pix);
                expected = {{2{rgbs[i][11:8]}}, {2{rgbs[i][7:4]}}, {2{rgbs[i][3:0]}}};
                actual = {decode_data(tmds.ch2), decode_data(tmds.ch1), decode_data(tmds.ch0)};
                check(name, expected, actual);
            end
            default: begin
                $display("unknown test kind %s", kinds[i]);
                errors++;
            end
        endcase
        report(name, errs);
    endtask

    // disparity on active lines and control codes on a vsync line over one frame
    task automatic scan_frame();
        int                   errs;
        int                   over;
        int                   disp [3];
        video_pkg::tmds_sym_t syms [3];
        bit                   hs;
        bit                   vs;
        errs = errors;
        over = 0;
        disp = '{0, 0, 0};
        wait_frame();
        for (int y = 0; y < video_pkg::v_total; y++) begin
            for (int x = 0; x < video_pkg::h_total; x++) begin
                @(negedge clk_pix);
                syms = '{tmds.ch0, tmds.ch1, tmds.ch2};
                if (x < video_pkg::h_active && y < video_pkg::v_active) begin
                    for (int c = 0; c < 3; c++) begin
                        if (x == 0) begin
                            disp[c] = 0;  // encoder restarts each line
                        end
                        disp[c] += 2 * $countones(syms[c]) - 10;
                        if (disp[c] > 10 || disp[c] < -10) begin
                            over++;
                        end
                    end
                end else if (y == video_pkg::v_sync_start) begin
                    hs = (x >= video_pkg::h_sync_start) && (x < video_pkg::h_sync_end);
                    vs = (y >= video_pkg::v_sync_start) && (y < video_pkg::v_sync_end);
                    check($sformatf("blank_ch0_x%0d", x), {vs, hs}, decode_ctrl(syms[0]));
                    check($sformatf("blank_ch1_x%0d", x), 0, decode_ctrl(syms[1]));
                    check($sformatf("blank_ch2_x%0d", x), 0, decode_ctrl(syms[2]));
                end
            end
        end
        report("blanking", errs);
        errs = errors;
        check("dc_balance", 0, over);
        report("dc_balance", errs);
    endtask

    initial begin
        clk_pix = 1'b0;
        arst_n  = 1'b0;
        wb_req  = '0;
        load_tests();
        repeat (16) @(posedge clk_pix);
        arst_n <= 1'b1;
        @(negedge clk_pix);  // no edge out of reset yet
        reset_errs = errors;
        check("reset_ch0", 10'b1101010100, tmds.ch0);
        check("reset_ch1", 10'b1101010100, tmds.ch1);
        check("reset_ch2", 10'b1101010100, tmds.ch2);
        check("reset_ack", 0, wb_rsp.ack);
        check("reset_frame_start", 0, frame_start);
        report("reset", reset_errs);
        for (int i = 0; i < kinds.size(); i++) begin
            run_vector(i);
        end
        scan_frame();
        finish_run();
    end

endmodule

`default_nettype wire

//--- test/video_tests.txt
# kind x y index rgb
# write/read use framebuffer coordinates, pixel uses screen coordinates
write  0  0 c 000
write  2  1 9 000
write 15 11 f 000
write  7  5 6 000
write  3 10 1 000
write  2  1 b 000
read   0  0 c 000
read   2  1 b 000
read   5  5 0 000
pixel  0  0 c f55
pixel  3  3 c f55
pixel  8  4 b 5ff
pixel 11  7 b 5ff
pixel 63 47 f fff
pixel 28 20 6 a50
pixel 13 42 1 00a
pixel 20 20 0 000
pixel  4  0 0 000

//--- filelist.f
common/video_pkg.sv
common/fb_pkg.sv
hw/display_timings.sv
framebuffer/framebuffer.sv
tmds/tmds_encoder.sv
hw/video_top.sv
test/video_properties.sv
test/tb_video_top.sv

//--- Bender.yml
package:
  name: video_pipeline

sources:
  - common/video_pkg.sv
  - common/fb_pkg.sv
  - hw/display_timings.sv
  - framebuffer/framebuffer.sv
  - tmds/tmds_encoder.sv
  - hw/video_top.sv
  - target: test
    files:
      - test/video_properties.sv
      - test/tb_video_top.sv
